//--- Bender.yml
package:
  name: mdu_array

sources:
  - hw/mdu_pkg.sv
  - hw/instr_fetcher.sv
  - hw/mdu_unit.sv
  - hw/result_drain.sv
  - hw/mdu_array_top.sv
  - target: simulation
    files:
      - sim/mdu_array_chk.sv
      - sim/mdu_array_tb.sv

//--- hw/instr_fetcher.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetcher import mdu_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 start,
    input  wire logic [NUM_UNITS-1:0] instr_credit,
    output logic                      mem_rd_en,
    output mem_addr_t                 mem_rd_addr,
    input  wire instr_t               mem_rd_data,
    output logic [NUM_UNITS-1:0]      instr_valid,
    output instr_t                    instr_data,
    output logic                      fetch_done
);

    fetch_state_e         state_q;
    prog_cnt_t            rd_cnt [NUM_UNITS];
    credit_t              credit_q [NUM_UNITS];
    logic [NUM_UNITS-1:0] cnt_full;
    logic [NUM_UNITS-1:0] eligible;
    logic [NUM_UNITS-1:0] grant_oh;
    logic                 grant_vld;
    unit_idx_t            grant_idx;
    // Read in flight, word arrives next cycle
    logic                 rd_pend_q;
    unit_idx_t            rd_idx_q;

    // ======================================
    // Arbitration
    // ======================================
    // Unit may fetch with credit left and program not finished
    always_comb begin
        for (int i = 0; i < NUM_UNITS; i++) begin
            cnt_full[i] = (rd_cnt[i] == prog_cnt_t'(PROG_LEN));
            eligible[i] = (state_q == FS_RUN) && (credit_q[i] != '0) && !cnt_full[i];
        end
    end

    // Fixed priority, lowest index wins
    always_comb begin
        grant_vld = 1'b0;
        grant_idx = '0;
        for (int i = NUM_UNITS - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                grant_vld = 1'b1;
                grant_idx = unit_idx_t'(i);
            end
        end
        grant_oh            = '0;
        grant_oh[grant_idx] = grant_vld;
    end

    // Memory read for the granted unit
    assign mem_rd_en   = grant_vld;
    assign mem_rd_addr = unit_base(grant_idx) + mem_addr_t'(rd_cnt[grant_idx]);

    // ======================================
    // State and counters
    // ======================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= FS_IDLE;
        end else if (start) begin
            state_q <= FS_RUN;
        end else if (state_q == FS_RUN && (&cnt_full)) begin
            state_q <= FS_IDLE;
        end
    end

    // Read counters restart on every start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_UNITS; i++) rd_cnt[i] <= '0;
        end else if (start) begin
            for (int i = 0; i < NUM_UNITS; i++) rd_cnt[i] <= '0;
        end else begin
            for (int i = 0; i < NUM_UNITS; i++) begin
                if (grant_oh[i]) rd_cnt[i] <= rd_cnt[i] + 1'b1;
            end
        end
    end

    // Read spends a credit, unit pop gives one back
    // Kept across start since it mirrors queue occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_UNITS; i++) credit_q[i] <= credit_t'(INSTR_DEPTH);
        end else begin
            for (int i = 0; i < NUM_UNITS; i++) begin
                credit_q[i] <= credit_q[i] - credit_t'(grant_oh[i])
                                           + credit_t'(instr_credit[i]);
            end
        end
    end

    // ======================================
    // Delivery
    // ======================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= grant_vld;
        end
    end

    always_ff @(posedge clk) begin
        rd_idx_q <= grant_idx;
    end

    // Returning word goes to the unit that asked for it
    always_comb begin
        instr_valid           = '0;
        instr_valid[rd_idx_q] = rd_pend_q;
    end

    assign instr_data = mem_rd_data;

    // All programs read and the last word handed over
    assign fetch_done = (&cnt_full) && !rd_pend_q;

endmodule

`default_nettype wire

//--- hw/mdu_array_top.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_array_top import mdu_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   start,
    output logic        mem_rd_en,
    output mem_addr_t   mem_rd_addr,
    input  wire instr_t mem_rd_data,
    output logic        res_valid,
    output result_t     res_data,
    input  wire logic   res_ready,
    output logic        done
);

    // Fetcher and unit side
    logic [NUM_UNITS-1:0] instr_valid;
    instr_t               instr_data;
    logic [NUM_UNITS-1:0] instr_credit;
    logic                 fetch_done;
    logic [NUM_UNITS-1:0] unit_idle;
    // Unit and drain side
    logic [NUM_UNITS-1:0] res_push;
    result_t              unit_res [NUM_UNITS];
    logic [NUM_UNITS-1:0] res_credit;
    logic                 drain_empty;

    // ======================================
    // Fetch
    // ======================================
    instr_fetcher u_fetcher (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .instr_credit (instr_credit),
        .mem_rd_en    (mem_rd_en),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_data  (mem_rd_data),
        .instr_valid  (instr_valid),
        .instr_data   (instr_data),
        .fetch_done   (fetch_done)
    );

    // ======================================
    // Units
    // ======================================
    for (genvar g = 0; g < NUM_UNITS; g++) begin : g_unit
        mdu_unit u_unit (
            .clk          (clk),
            .rst_n        (rst_n),
            .start        (start),
            .instr_valid  (instr_valid[g]),
            .instr_data   (instr_data),
            .instr_credit (instr_credit[g]),
            .res_push     (res_push[g]),
            .res_data     (unit_res[g]),
            .res_credit   (res_credit[g]),
            .unit_id      (unit_idx_t'(g)),
            .idle         (unit_idle[g])
        );
    end

    // ======================================
    // Drain
    // ======================================
    result_drain u_drain (
        .clk          (clk),
        .rst_n        (rst_n),
        .res_push     (res_push),
        .res_data     (unit_res),
        .res_credit   (res_credit),
        .res_valid    (res_valid),
        .res_data_out (res_data),
        .res_ready    (res_ready),
        .empty        (drain_empty)
    );

    // Everything fetched, executed and sent out
    // Sticky until the next start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b0;
        end else if (fetch_done && (&unit_idle) && drain_empty) begin
            done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/mdu_pkg.sv
`default_nettype none

package mdu_pkg;

    // ======================================
    // Sizes
    // ======================================
    localparam int NUM_UNITS        = 4;
    localparam int PROG_LEN         = 16;
    // Queue depth per unit, also the starting fetch credit
    localparam int INSTR_DEPTH      = 2;
    localparam int MEM_AW           = 8;
    // Spacing of unit programs in memory
    localparam int UNIT_BASE_STRIDE = 64;

    // ======================================
    // Scalar types
    // ======================================
    typedef logic [$clog2(NUM_UNITS)-1:0]     unit_idx_t;
    typedef logic [MEM_AW-1:0]                mem_addr_t;
    typedef logic [15:0]                      operand_t;
    // Holds 0 up to PROG_LEN
    typedef logic [$clog2(PROG_LEN+1)-1:0]    prog_cnt_t;
    // Holds 0 up to INSTR_DEPTH
    typedef logic [$clog2(INSTR_DEPTH+1)-1:0] credit_t;

    typedef enum logic [1:0] {
        OP_ADD   = 2'd0,
        OP_XOR   = 2'd1,
        OP_CLR   = 2'd2,
        OP_FLUSH = 2'd3
    } opcode_e;

    typedef enum logic {
        FS_IDLE = 1'b0,
        FS_RUN  = 1'b1
    } fetch_state_e;

    // ======================================
    // Structs
    // ======================================
    // Instruction word, same layout as a memory word
    typedef struct packed {
        opcode_e  op;
        operand_t operand;
    } instr_t;

    // Result tagged with its source unit
    typedef struct packed {
        unit_idx_t unit;
        operand_t  value;
    } result_t;

    // Program start of a unit
    function automatic mem_addr_t unit_base(unit_idx_t idx);
        return mem_addr_t'(UNIT_BASE_STRIDE * idx);
    endfunction

endpackage

`default_nettype wire

//--- hw/mdu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_unit import mdu_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      start,
    input  wire logic      instr_valid,
    input  wire instr_t    instr_data,
    output logic           instr_credit,
    output logic           res_push,
    output result_t        res_data,
    input  wire logic      res_credit,
    input  wire unit_idx_t unit_id,
    output logic           idle
);

    // ======================================
    // Instruction queue
    // ======================================
    instr_t                         q_mem [INSTR_DEPTH];
    // Pointers wrap naturally for a power of two depth
    logic [$clog2(INSTR_DEPTH)-1:0] wr_ptr;
    logic [$clog2(INSTR_DEPTH)-1:0] rd_ptr;
    credit_t                        q_cnt;
    instr_t                         head;
    logic                           pop;
    // One slot in the drain per unit
    logic                           res_cred_q;
    operand_t                       acc_q;

    always_ff @(posedge clk) begin
        if (instr_valid) q_mem[wr_ptr] <= instr_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_cnt  <= '0;
        end else begin
            if (instr_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            q_cnt <= q_cnt + credit_t'(instr_valid) - credit_t'(pop);
        end
    end

    assign head = q_mem[rd_ptr];

    // Flush stalls at the head until a result credit is held
    assign pop = (q_cnt != '0) && ((head.op != OP_FLUSH) || res_cred_q);

    // Each pop frees one entry at the fetcher
    assign instr_credit = pop;
    assign idle         = (q_cnt == '0);

    // ======================================
    // Datapath
    // ======================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (start) begin
            acc_q <= '0;
        end else if (pop) begin
            case (head.op)
                OP_ADD:  acc_q <= acc_q + head.operand;
                OP_XOR:  acc_q <= acc_q ^ head.operand;
                OP_CLR:  acc_q <= '0;
                // Flush leaves the accumulator alone
                default: acc_q <= acc_q;
            endcase
        end
    end

    // Result goes out in the pop cycle
    assign res_push = pop && (head.op == OP_FLUSH);
    assign res_data = '{unit: unit_id, value: acc_q};

    // Push spends the credit, drain forwarding returns it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_cred_q <= 1'b1;
        end else begin
            res_cred_q <= (res_cred_q && !res_push) || res_credit;
        end
    end

endmodule

`default_nettype wire

//--- hw/result_drain.sv
`timescale 1ns/1ps
`default_nettype none

module result_drain import mdu_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic [NUM_UNITS-1:0] res_push,
    input  wire result_t              res_data [NUM_UNITS],
    output logic [NUM_UNITS-1:0]      res_credit,
    output logic                      res_valid,
    output result_t                   res_data_out,
    input  wire logic                 res_ready,
    output logic                      empty
);

    logic [NUM_UNITS-1:0] slot_vld;
    result_t              slot_data [NUM_UNITS];
    // Next unit to look at first
    unit_idx_t            rr_ptr;
    unit_idx_t            pick_idx;
    logic                 pick_vld;
    logic                 load;
    logic                 out_vld;
    result_t              out_data;

    // ======================================
    // Per-unit slots
    // ======================================
    // Unit credit keeps push and release of one slot apart
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_vld <= '0;
        end else begin
            slot_vld <= (slot_vld & ~res_credit) | res_push;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (res_push[i]) slot_data[i] <= res_data[i];
        end
    end

    // ======================================
    // Round-robin pick
    // ======================================
    always_comb begin
        unit_idx_t cand;
        pick_vld = 1'b0;
        pick_idx = rr_ptr;
        // Walk down so the smallest offset from rr_ptr wins
        for (int k = NUM_UNITS - 1; k >= 0; k--) begin
            cand = rr_ptr + unit_idx_t'(k);
            if (slot_vld[cand]) begin
                pick_vld = 1'b1;
                pick_idx = cand;
            end
        end
    end

    // Output stage free or draining this cycle
    assign load = pick_vld && (!out_vld || res_ready);

    // Credit back to the unit whose slot moves out
    always_comb begin
        res_credit           = '0;
        res_credit[pick_idx] = load;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (load) begin
            rr_ptr <= pick_idx + 1'b1;
        end
    end

    // ======================================
    // Output stage
    // ======================================
    // Held steady while res_ready is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld <= 1'b0;
        end else if (load) begin
            out_vld <= 1'b1;
        end else if (res_ready) begin
            out_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) out_data <= slot_data[pick_idx];
    end

    assign res_valid    = out_vld;
    assign res_data_out = out_data;
    assign empty        = !(|slot_vld) && !out_vld;

endmodule

`default_nettype wire

//--- sim/mdu_array_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_array_chk import mdu_pkg::*; (
    input wire logic                 clk,
    input wire logic                 rst_n,
    input wire logic [NUM_UNITS-1:0] instr_valid,
    input wire logic [NUM_UNITS-1:0] instr_credit,
    input wire logic [NUM_UNITS-1:0] res_push,
    input wire logic [NUM_UNITS-1:0] res_credit,
    input wire logic                 res_valid,
    input wire logic                 res_ready,
    input wire result_t              res_data
);

    // Failed assertions so far, read by the testbench
    int                   chk_errs = 0;
    // Queue fill per unit, seen from deliveries and pops
    logic [2:0]           occ [NUM_UNITS];
    // Drain slot taken and credit not yet back
    logic [NUM_UNITS-1:0] res_held;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_UNITS; i++) occ[i] <= '0;
            res_held <= '0;
        end else begin
            for (int i = 0; i < NUM_UNITS; i++) begin
                occ[i] <= occ[i] + 3'(instr_valid[i]) - 3'(instr_credit[i]);
            end
            res_held <= (res_held & ~res_credit) | res_push;
        end
    end

    // ======================================
    // Credit bounds
    // ======================================
    for (genvar g = 0; g < NUM_UNITS; g++) begin : g_unit
        // Queue never holds more than its depth
        a_queue_bound: assert property (@(posedge clk) disable iff (!rst_n)
            occ[g] <= 3'(INSTR_DEPTH))
        else begin
            $error("unit %0d queue holds %0d entries", g, occ[g]);
            chk_errs++;
        end

        // Push only with the result credit in hand
        a_push_credit: assert property (@(posedge clk) disable iff (!rst_n)
            res_push[g] |-> !res_held[g])
        else begin
            $error("unit %0d pushed a result without a credit", g);
            chk_errs++;
        end
    end

    // ======================================
    // Output port
    // ======================================
    // Stalled result stays put
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid && $stable(res_data))
    else begin
        $error("result output changed while stalled");
        chk_errs++;
    end

endmodule

bind mdu_array_top mdu_array_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr_credit (instr_credit),
    .res_push     (res_push),
    .res_credit   (res_credit),
    .res_valid    (res_valid),
    .res_ready    (res_ready),
    .res_data     (res_data)
);

`default_nettype wire

//--- sim/mdu_array_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_array_tb import mdu_pkg::*; ();

    localparam int MEM_WORDS   = 1 << MEM_AW;
    // Eight cycles per word worst case plus slack
    localparam int TIMEOUT_CYC = NUM_UNITS * PROG_LEN * 8 + 200;

    logic      clk;
    logic      rst_n;
    logic      start;
    logic      mem_rd_en;
    mem_addr_t mem_rd_addr;
    instr_t    mem_rd_data;
    logic      res_valid;
    result_t   res_data;
    logic      res_ready;
    logic      done;

    // Memory image and expected results per unit
    instr_t    mem [MEM_WORDS];
    operand_t  exp_val [NUM_UNITS][PROG_LEN];
    int        exp_wr [NUM_UNITS];
    int        exp_rd [NUM_UNITS];
    int        flush_cnt;
    int        res_cnt;
    // Bookkeeping
    string     cur_test;
    int        test_errs;
    int        total_errs;
    int        tests_run;
    int        tests_failed;
    int        last_chk;
    int        wait_cyc;
    logic      waiting;
    logic      bp_on;
    logic      stall_q;
    result_t   held_q;

    mdu_array_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_data (mem_rd_data),
        .res_valid   (res_valid),
        .res_data    (res_data),
        .res_ready   (res_ready),
        .done        (done)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ========================================
    // Memory, back-pressure and watchdog
    // ========================================
    // One cycle read latency
    always @(posedge clk) begin
        if (mem_rd_en) mem_rd_data <= #2 mem[mem_rd_addr];
    end

    // Ready high on 30 percent of cycles when stalls are on
    always @(posedge clk) begin
        #2;
        res_ready = bp_on ? ($urandom_range(99) < 30) : 1'b1;
    end

    always @(negedge clk) begin
        if (!waiting) begin
            wait_cyc = 0;
        end else if (wait_cyc < TIMEOUT_CYC) begin
            wait_cyc++;
        end else begin
            $display("Timeout: %s not done after %0d cycles", cur_test, TIMEOUT_CYC);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ========================================
    // Output monitor
    // ========================================
    // Compare one result with the head of its unit's queue
    task automatic check_result(input result_t r);
        int u;
        u = int'(r.unit);
        res_cnt++;
        assert (exp_rd[u] < exp_wr[u]) else begin
            $display("%s: unit %0d sent a result with none expected", cur_test, u);
            test_errs++;
        end
        if (exp_rd[u] < exp_wr[u]) begin
            assert (r.value == exp_val[u][exp_rd[u]]) else begin
                $display("** Error %s: unit %0d result %0d expected %h actual %h",
                         cur_test, u, exp_rd[u], exp_val[u][exp_rd[u]], r.value);
                test_errs++;
            end
            exp_rd[u]++;
        end
    endtask

    // Transfer happens at the next rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (stall_q) begin
                assert (res_valid && res_data == held_q) else begin
                    $display("** Error %s: stalled output expected %h actual %h",
                             cur_test, held_q, res_data);
                    test_errs++;
                end
            end
            if (res_valid && res_ready) check_result(res_data);
            stall_q = res_valid && !res_ready;
            held_q  = res_data;
        end
    end

    // ========================================
    // Stimulus and reference model
    // ========================================
    task automatic fill_memory(input bit flush_heavy);
        opcode_e op;
        for (int a = 0; a < MEM_WORDS; a++) begin
            if (!flush_heavy) begin
                op = opcode_e'($urandom_range(3));
            end else if ($urandom_range(99) < 85) begin
                op = OP_FLUSH;
            end else begin
                op = opcode_e'($urandom_range(2));
            end
            mem[a] = '{op: op, operand: operand_t'($urandom)};
        end
    endtask

    // Replay every program from a zero accumulator
    task automatic build_expected();
        operand_t acc;
        instr_t   w;
        flush_cnt = 0;
        res_cnt   = 0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            acc       = '0;
            exp_wr[u] = 0;
            exp_rd[u] = 0;
            for (int k = 0; k < PROG_LEN; k++) begin
                w = mem[u * UNIT_BASE_STRIDE + k];
                case (w.op)
                    OP_ADD: acc = acc + w.operand;
                    OP_XOR: acc = acc ^ w.operand;
                    OP_CLR: acc = '0;
                    default: begin
                        exp_val[u][exp_wr[u]] = acc;
                        exp_wr[u]++;
                        flush_cnt++;
                    end
                endcase
            end
        end
    endtask

    // Start pulse, then wait for done under the watchdog
    task automatic run_program();
        build_expected();
        @(posedge clk);
        #2 start = 1'b1;
        @(posedge clk);
        #2 start = 1'b0;
        waiting = 1'b1;
        @(negedge clk);
        while (!done) @(negedge clk);
        waiting = 1'b0;
    endtask

    task automatic check_complete();
        for (int u = 0; u < NUM_UNITS; u++) begin
            assert (exp_rd[u] == exp_wr[u]) else begin
                $display("%s: unit %0d is missing %0d results after done",
                         cur_test, u, exp_wr[u] - exp_rd[u]);
                test_errs++;
            end
        end
        assert (res_cnt == flush_cnt) else begin
            $display("** Error %s: result count expected %0d actual %0d",
                     cur_test, flush_cnt, res_cnt);
            test_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    // Checker failures in this test count too
    task automatic end_test();
        test_errs += DUT.u_chk.chk_errs - last_chk;
        last_chk = DUT.u_chk.chk_errs;
        if (test_errs == 0) begin
            $display("%-16s ok", cur_test);
        end else begin
            $display("%-16s failed with %0d errors", cur_test, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
        tests_run++;
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        rst_n        = 1'b0;
        start        = 1'b0;
        res_ready    = 1'b1;
        mem_rd_data  = '0;
        bp_on        = 1'b0;
        waiting      = 1'b0;
        stall_q      = 1'b0;
        held_q       = '0;
        cur_test     = "reset";
        test_errs    = 0;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        last_chk     = 0;
        void'($urandom(32'h7df2));
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;

        begin_test("random_results");
        assert (!mem_rd_en && !res_valid && !done) else begin
            $display("%s: outputs not idle after reset", cur_test);
            test_errs++;
        end
        fill_memory(1'b0);
        run_program();
        end_test();

        // Covers the run of the previous test
        begin_test("completeness");
        check_complete();
        end_test();

        begin_test("back_pressure");
        fill_memory(1'b0);
        bp_on = 1'b1;
        run_program();
        check_complete();
        end_test();

        begin_test("flush_heavy");
        fill_memory(1'b1);
        run_program();
        check_complete();
        end_test();

        // Second start right after done must clear the accumulators
        begin_test("restart");
        bp_on = 1'b0;
        fill_memory(1'b0);
        run_program();
        check_complete();
        run_program();
        check_complete();
        end_test();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hw/mdu_pkg.sv
hw/instr_fetcher.sv
hw/mdu_unit.sv
hw/result_drain.sv
hw/mdu_array_top.sv
sim/mdu_array_chk.sv
sim/mdu_array_tb.sv
